// ==== list.f ====
src/mem_pkg.sv
src/mem_fu.sv
src/dcache_array.sv
src/fill_fsm.sv
src/fill_timer.sv
src/store_queue.sv
src/mem_backing.sv
src/mem_subsystem.sv
tb/mem_subsystem_chk.sv
tb/mem_subsystem_tb.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module mem_subsystem_tb -f list.f -o sim

out=$(./obj_dir/sim +verilator+error+limit+1000)
echo "$out"

if echo "$out" | grep -q "All checks passed"; then
    exit 0
fi
exit 1

// ==== src/dcache_array.sv ====
`timescale 1ns/1ps

module dcache_array import mem_pkg::*; (
    input  logic               clock,
    input  logic               reset,
    input  logic [TAG_W-1:0]   lookup_tag,
    input  logic [OFFS_W-1:0]  lookup_offset,
    input  logic               fill_en,
    input  logic [TAG_W-1:0]   fill_tag,
    input  logic [OFFS_W-1:0]  fill_offset,
    input  logic [BLOCK_W-1:0] fill_data,
    input  logic               inval_en,
    input  logic [TAG_W-1:0]   inval_tag,
    input  logic [OFFS_W-1:0]  inval_offset,
    output logic               hit,
    output logic [BLOCK_W-1:0] hit_data
);

    localparam int LINES = 1 << OFFS_W;

    logic [LINES-1:0]   line_valid;
    logic [TAG_W-1:0]   line_tag  [LINES];
    logic [BLOCK_W-1:0] line_data [LINES];

    // Tag the invalidate compares against, including a same-cycle fill
    logic [TAG_W-1:0] inval_cmp_tag;
    logic             inval_match;

    // Direct-mapped lookup
    assign hit      = line_valid[lookup_offset] && (line_tag[lookup_offset] == lookup_tag);
    assign hit_data = line_data[lookup_offset];

    always_comb begin
        if (fill_en && (fill_offset == inval_offset)) begin
            inval_cmp_tag = fill_tag;
        end else begin
            inval_cmp_tag = line_tag[inval_offset];
        end
    end

    // Fill to the same line counts as present
    assign inval_match = inval_en && (inval_cmp_tag == inval_tag) &&
                         (line_valid[inval_offset] ||
                          (fill_en && (fill_offset == inval_offset)));

    // Valid bits, invalidate applied last so it wins
    always_ff @(posedge clock) begin
        if (reset) begin
            line_valid <= '0;
        end else begin
            if (fill_en) begin
                line_valid[fill_offset] <= 1'b1;
            end
            if (inval_match) begin
                line_valid[inval_offset] <= 1'b0;
            end
        end
    end

    // Tag and data arrays
    always_ff @(posedge clock) begin
        if (fill_en) begin
            line_tag[fill_offset]  <= fill_tag;
            line_data[fill_offset] <= fill_data;
        end
    end

endmodule

// ==== src/fill_fsm.sv ====
`timescale 1ns/1ps

module fill_fsm import mem_pkg::*; (
    input  logic              clock,
    input  logic              reset,
    input  logic              load_req,
    input  logic              hit,
    input  logic [TAG_W-1:0]  req_tag,
    input  logic [OFFS_W-1:0] req_offset,
    input  logic              timer_done,
    output logic              timer_start,
    output logic              fill_en,
    output logic [TAG_W-1:0]  fill_tag,
    output logic [OFFS_W-1:0] fill_offset
);

    typedef enum logic [1:0] {
        IDLE,
        WAIT,
        FILL
    } state_t;

    state_t state;

    // New miss only accepted while idle
    assign timer_start = (state == IDLE) && load_req && !hit;
    assign fill_en     = (state == FILL);

    always_ff @(posedge clock) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            case (state)
                IDLE:    if (timer_start) state <= WAIT;
                WAIT:    if (timer_done) state <= FILL;
                FILL:    state <= IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // Missing address held until the fill pulse
    always_ff @(posedge clock) begin
        if (timer_start) begin
            fill_tag    <= req_tag;
            fill_offset <= req_offset;
        end
    end

endmodule

// ==== src/fill_timer.sv ====
`timescale 1ns/1ps

module fill_timer import mem_pkg::*; (
    input  logic clock,
    input  logic reset,
    input  logic start,
    output logic done
);

    // Remaining latency cycles, zero when idle
    logic [TIMER_W-1:0] count;

    // Last counted cycle, count goes to zero at this edge
    assign done = (count == TIMER_W'(1));

    always_ff @(posedge clock) begin
        if (reset) begin
            count <= '0;
        end else if (start) begin
            count <= TIMER_W'(MISS_LATENCY);
        end else if (count != '0) begin
            count <= count - 1'b1;
        end
    end

endmodule

// ==== src/mem_backing.sv ====
`timescale 1ns/1ps

module mem_backing import mem_pkg::*; (
    input  logic               clock,
    input  logic               reset,
    input  logic [TAG_W-1:0]   rd_tag,
    input  logic [OFFS_W-1:0]  rd_offset,
    input  logic               we,
    input  logic [DATA_W-1:0]  waddr,
    input  logic [DATA_W-1:0]  wdata,
    output logic [BLOCK_W-1:0] rd_data
);

    logic [BLOCK_W-1:0]   mem [MEM_BLOCKS];
    logic [MEM_IDX_W-1:0] rd_idx;
    logic [MEM_IDX_W-1:0] wr_idx;

    // Low tag bits select the page, offset the block within it
    assign rd_idx = {rd_tag[MEM_IDX_W-OFFS_W-1:0], rd_offset};
    assign wr_idx = {waddr[TAG_LSB +: MEM_IDX_W-OFFS_W], waddr[OFFS_LSB +: OFFS_W]};

    assign rd_data = mem[rd_idx];

    // Known pattern at reset, same value in both words
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < MEM_BLOCKS; i++) begin
                mem[i] <= {2{mem_init_word(i)}};
            end
        end else if (we) begin
            // Upper word when bit 2 is set
            if (waddr[WORD_SEL_BIT]) begin
                mem[wr_idx][BLOCK_W-1:DATA_W] <= wdata;
            end else begin
                mem[wr_idx][DATA_W-1:0] <= wdata;
            end
        end
    end

endmodule

// ==== src/mem_fu.sv ====
`timescale 1ns/1ps

module mem_fu import mem_pkg::*; (
    input  logic                clock,
    input  logic                reset,
    input  logic                valid,
    input  mem_func_t           func,
    input  logic [DATA_W-1:0]   rs1,
    input  logic [DATA_W-1:0]   rs2,
    input  logic [DATA_W-1:0]   imm,
    input  logic [SQ_IDX_W-1:0] store_queue_idx,
    input  logic [PTAG_W-1:0]   dest_tag,
    input  logic                hit,
    input  logic [BLOCK_W-1:0]  hit_data,
    output logic                load_req,
    output logic [TAG_W-1:0]    dcache_tag,
    output logic [OFFS_W-1:0]   dcache_offset,
    output logic                sq_write,
    output logic [DATA_W-1:0]   sq_addr,
    output logic [DATA_W-1:0]   sq_data,
    output logic [SQ_IDX_W-1:0] sq_idx,
    output logic                cdb_request,
    output logic                cdb_valid,
    output logic [PTAG_W-1:0]   cdb_tag,
    output logic [BLOCK_W-1:0]  cdb_data,
    output logic                busy
);

    // ========================================================================
    // Address generation and classification
    // ========================================================================

    logic [DATA_W-1:0] eff_addr;
    logic [TAG_W-1:0]  new_tag;
    logic [OFFS_W-1:0] new_offset;
    logic              is_load;
    logic              is_store;

    // Pending miss, one at a time
    logic              pend_valid;
    logic [PTAG_W-1:0] pend_dest;
    logic [TAG_W-1:0]  pend_tag;
    logic [OFFS_W-1:0] pend_offset;

    logic pend_hit;
    logic new_hit;
    logic new_miss;

    assign eff_addr   = rs1 + imm;
    assign new_tag    = eff_addr[TAG_LSB +: TAG_W];
    assign new_offset = eff_addr[OFFS_LSB +: OFFS_W];

    // Size and signedness do not matter here, only direction
    assign is_load  = (func == LOAD_BYTE)   || (func == LOAD_HALF)   ||
                      (func == LOAD_WORD)   || (func == LOAD_DOUBLE) ||
                      (func == LOAD_BYTE_U) || (func == LOAD_HALF_U);
    assign is_store = (func == STORE_BYTE)  || (func == STORE_HALF)  ||
                      (func == STORE_WORD)  || (func == STORE_DOUBLE);

    // ========================================================================
    // Cache request
    // ========================================================================

    // Pending load keeps the port until it hits
    always_comb begin
        load_req      = 1'b0;
        dcache_tag    = '0;
        dcache_offset = '0;
        if (pend_valid) begin
            load_req      = 1'b1;
            dcache_tag    = pend_tag;
            dcache_offset = pend_offset;
        end else if (valid && is_load) begin
            load_req      = 1'b1;
            dcache_tag    = new_tag;
            dcache_offset = new_offset;
        end
    end

    assign pend_hit = pend_valid && hit;
    assign new_hit  = !pend_valid && valid && is_load && hit;
    assign new_miss = !pend_valid && valid && is_load && !hit;

    // Store goes straight to the queue
    assign sq_write = valid && is_store;
    assign sq_addr  = eff_addr;
    assign sq_data  = rs2;
    assign sq_idx   = store_queue_idx;

    // ========================================================================
    // CDB result
    // ========================================================================

    always_comb begin
        cdb_request = 1'b0;
        cdb_valid   = 1'b0;
        cdb_tag     = '0;
        cdb_data    = '0;
        if (pend_hit) begin
            cdb_request = 1'b1;
            cdb_valid   = 1'b1;
            cdb_tag     = pend_dest;
            cdb_data    = hit_data;
        end else if (new_hit) begin
            cdb_request = 1'b1;
            cdb_valid   = 1'b1;
            cdb_tag     = dest_tag;
            cdb_data    = hit_data;
        end else if (valid && is_store) begin
            // Store only signals completion, no register result
            cdb_request = 1'b1;
        end
    end

    // Pending flag, cleared on the completing hit
    always_ff @(posedge clock) begin
        if (reset) begin
            pend_valid <= 1'b0;
        end else if (pend_hit) begin
            pend_valid <= 1'b0;
        end else if (new_miss) begin
            pend_valid <= 1'b1;
        end
    end

    // Miss payload
    always_ff @(posedge clock) begin
        if (new_miss) begin
            pend_dest   <= dest_tag;
            pend_tag    <= new_tag;
            pend_offset <= new_offset;
        end
    end

    assign busy = pend_valid;

endmodule

// ==== src/mem_pkg.sv ====
package mem_pkg;

    // ========================================================================
    // Datapath widths
    // ========================================================================

    // Register operands and store data
    localparam int DATA_W   = 32;
    // Cache line, fill data and CDB payload
    localparam int BLOCK_W  = 64;
    // Physical destination tag on the CDB
    localparam int PTAG_W   = 6;

    // ========================================================================
    // Address split
    // ========================================================================

    // Tag is address bits 31 to 12
    localparam int TAG_W    = 20;
    localparam int TAG_LSB  = 12;
    // Block offset (line index) is address bits 4 to 3
    localparam int OFFS_W   = 2;
    localparam int OFFS_LSB = 3;
    // Bit 2 picks the 32-bit word inside a block
    localparam int WORD_SEL_BIT = 2;

    // ========================================================================
    // Store queue, backing memory and miss timing
    // ========================================================================

    localparam int SQ_IDX_W   = 2;
    localparam int SQ_DEPTH   = 4;
    localparam int MEM_BLOCKS = 16;
    // Backing index is low tag bits followed by the offset
    localparam int MEM_IDX_W  = $clog2(MEM_BLOCKS);
    localparam int MISS_LATENCY = 6;
    localparam int TIMER_W    = $clog2(MISS_LATENCY + 1);
    // Odd multiplier for the reset fill pattern
    localparam logic [DATA_W-1:0] MEM_INIT_MULT = 32'h9E37_79B1;

    // Operation codes from the issue stage
    typedef enum logic [3:0] {
        LOAD_BYTE,
        LOAD_HALF,
        LOAD_WORD,
        LOAD_DOUBLE,
        LOAD_BYTE_U,
        LOAD_HALF_U,
        STORE_BYTE,
        STORE_HALF,
        STORE_WORD,
        STORE_DOUBLE,
        MEM_NOP
    } mem_func_t;

    // Reset value of one word of backing block i
    function automatic logic [DATA_W-1:0] mem_init_word(input int i);
        return DATA_W'(i) * MEM_INIT_MULT;
    endfunction

endpackage

// ==== src/mem_subsystem.sv ====
`timescale 1ns/1ps

module mem_subsystem import mem_pkg::*; (
    input  logic                clock,
    input  logic                reset,
    input  logic                valid,
    input  mem_func_t           func,
    input  logic [DATA_W-1:0]   rs1,
    input  logic [DATA_W-1:0]   rs2,
    input  logic [DATA_W-1:0]   imm,
    input  logic [SQ_IDX_W-1:0] store_queue_idx,
    input  logic [PTAG_W-1:0]   dest_tag,
    input  logic                retire,
    input  logic [SQ_IDX_W-1:0] retire_idx,
    output logic                cdb_request,
    output logic                cdb_valid,
    output logic [PTAG_W-1:0]   cdb_tag,
    output logic [BLOCK_W-1:0]  cdb_data,
    output logic                busy
);

    // ========================================================================
    // Interconnect
    // ========================================================================

    // Cache lookup
    logic               load_req;
    logic [TAG_W-1:0]   dcache_tag;
    logic [OFFS_W-1:0]  dcache_offset;
    logic               hit;
    logic [BLOCK_W-1:0] hit_data;

    // Miss handling and fill
    logic               timer_start;
    logic               timer_done;
    logic               fill_en;
    logic [TAG_W-1:0]   fill_tag;
    logic [OFFS_W-1:0]  fill_offset;
    logic [BLOCK_W-1:0] fill_data;

    // Store path
    logic                sq_write;
    logic [DATA_W-1:0]   sq_addr;
    logic [DATA_W-1:0]   sq_data;
    logic [SQ_IDX_W-1:0] sq_idx;
    logic                mem_we;
    logic [DATA_W-1:0]   mem_addr;
    logic [DATA_W-1:0]   mem_wdata;

    mem_fu u_mem_fu (
        .clock           (clock),
        .reset           (reset),
        .valid           (valid),
        .func            (func),
        .rs1             (rs1),
        .rs2             (rs2),
        .imm             (imm),
        .store_queue_idx (store_queue_idx),
        .dest_tag        (dest_tag),
        .hit             (hit),
        .hit_data        (hit_data),
        .load_req        (load_req),
        .dcache_tag      (dcache_tag),
        .dcache_offset   (dcache_offset),
        .sq_write        (sq_write),
        .sq_addr         (sq_addr),
        .sq_data         (sq_data),
        .sq_idx          (sq_idx),
        .cdb_request     (cdb_request),
        .cdb_valid       (cdb_valid),
        .cdb_tag         (cdb_tag),
        .cdb_data        (cdb_data),
        .busy            (busy)
    );

    // Retired store also drops the cached copy of its line
    dcache_array u_dcache_array (
        .clock         (clock),
        .reset         (reset),
        .lookup_tag    (dcache_tag),
        .lookup_offset (dcache_offset),
        .fill_en       (fill_en),
        .fill_tag      (fill_tag),
        .fill_offset   (fill_offset),
        .fill_data     (fill_data),
        .inval_en      (mem_we),
        .inval_tag     (mem_addr[TAG_LSB +: TAG_W]),
        .inval_offset  (mem_addr[OFFS_LSB +: OFFS_W]),
        .hit           (hit),
        .hit_data      (hit_data)
    );

    fill_fsm u_fill_fsm (
        .clock       (clock),
        .reset       (reset),
        .load_req    (load_req),
        .hit         (hit),
        .req_tag     (dcache_tag),
        .req_offset  (dcache_offset),
        .timer_done  (timer_done),
        .timer_start (timer_start),
        .fill_en     (fill_en),
        .fill_tag    (fill_tag),
        .fill_offset (fill_offset)
    );

    fill_timer u_fill_timer (
        .clock (clock),
        .reset (reset),
        .start (timer_start),
        .done  (timer_done)
    );

    store_queue u_store_queue (
        .clock      (clock),
        .reset      (reset),
        .write      (sq_write),
        .write_idx  (sq_idx),
        .write_addr (sq_addr),
        .write_data (sq_data),
        .retire     (retire),
        .retire_idx (retire_idx),
        .mem_we     (mem_we),
        .mem_addr   (mem_addr),
        .mem_wdata  (mem_wdata)
    );

    // Fill reads at the address the FSM holds
    mem_backing u_mem_backing (
        .clock     (clock),
        .reset     (reset),
        .rd_tag    (fill_tag),
        .rd_offset (fill_offset),
        .we        (mem_we),
        .waddr     (mem_addr),
        .wdata     (mem_wdata),
        .rd_data   (fill_data)
    );

endmodule

// ==== src/store_queue.sv ====
`timescale 1ns/1ps

module store_queue import mem_pkg::*; (
    input  logic                clock,
    input  logic                reset,
    input  logic                write,
    input  logic [SQ_IDX_W-1:0] write_idx,
    input  logic [DATA_W-1:0]   write_addr,
    input  logic [DATA_W-1:0]   write_data,
    input  logic                retire,
    input  logic [SQ_IDX_W-1:0] retire_idx,
    output logic                mem_we,
    output logic [DATA_W-1:0]   mem_addr,
    output logic [DATA_W-1:0]   mem_wdata
);

    logic [SQ_DEPTH-1:0] entry_valid;
    logic [DATA_W-1:0]   entry_addr [SQ_DEPTH];
    logic [DATA_W-1:0]   entry_data [SQ_DEPTH];

    // Retire of an empty slot is ignored
    logic drain;
    assign drain = retire && entry_valid[retire_idx];

    // Control state, a write to the retiring slot survives
    always_ff @(posedge clock) begin
        if (reset) begin
            entry_valid <= '0;
            mem_we      <= 1'b0;
        end else begin
            mem_we <= drain;
            if (drain) begin
                entry_valid[retire_idx] <= 1'b0;
            end
            if (write) begin
                entry_valid[write_idx] <= 1'b1;
            end
        end
    end

    // Entry payload and the registered memory write
    always_ff @(posedge clock) begin
        if (write) begin
            entry_addr[write_idx] <= write_addr;
            entry_data[write_idx] <= write_data;
        end
        if (drain) begin
            mem_addr  <= entry_addr[retire_idx];
            mem_wdata <= entry_data[retire_idx];
        end
    end

endmodule

// ==== tb/mem_subsystem_chk.sv ====
`timescale 1ns/1ps

module mem_subsystem_chk import mem_pkg::*; (
    input logic                clock,
    input logic                reset,
    input logic                valid,
    input mem_func_t           func,
    input logic [DATA_W-1:0]   rs1,
    input logic [DATA_W-1:0]   rs2,
    input logic [DATA_W-1:0]   imm,
    input logic [SQ_IDX_W-1:0] store_queue_idx,
    input logic [PTAG_W-1:0]   dest_tag,
    input logic                retire,
    input logic [SQ_IDX_W-1:0] retire_idx,
    input logic                cdb_request,
    input logic                cdb_valid,
    input logic [PTAG_W-1:0]   cdb_tag,
    input logic [BLOCK_W-1:0]  cdb_data,
    input logic                busy
);

    // Count of failed assertions
    int fail_count = 0;

    // Shadow of backing memory and of the store queue
    logic [BLOCK_W-1:0]   shadow [MEM_BLOCKS];
    logic [SQ_DEPTH-1:0]  sq_live;
    logic [DATA_W-1:0]    sq_addr_sh [SQ_DEPTH];
    logic [DATA_W-1:0]    sq_data_sh [SQ_DEPTH];
    logic [MEM_IDX_W-1:0] issue_idx;
    logic [MEM_IDX_W-1:0] ret_idx;
    logic                 is_load;
    logic                 is_store;
    logic                 new_load;

    // Outstanding miss as seen from the ports
    logic                 pend;
    int                   age;
    logic [MEM_IDX_W-1:0] exp_idx;
    logic [PTAG_W-1:0]    exp_dest;

    // Block number is tag bits 13:12 then offset bits 4:3
    function automatic logic [MEM_IDX_W-1:0] block_of(input logic [DATA_W-1:0] a);
        return {a[TAG_LSB +: MEM_IDX_W-OFFS_W], a[OFFS_LSB +: OFFS_W]};
    endfunction

    task automatic flag(input string what);
        fail_count++;
        $error("%s", what);
    endtask

    assign is_load   = func inside {LOAD_BYTE, LOAD_HALF, LOAD_WORD,
                                    LOAD_DOUBLE, LOAD_BYTE_U, LOAD_HALF_U};
    assign is_store  = func inside {STORE_BYTE, STORE_HALF, STORE_WORD, STORE_DOUBLE};
    assign new_load  = valid && is_load && !busy;
    assign issue_idx = block_of(rs1 + imm);
    assign ret_idx   = block_of(sq_addr_sh[retire_idx]);

    // ========================================================================
    // Shadow model
    // ========================================================================

    // Retired word lands here one cycle before the DUT memory write
    always_ff @(posedge clock) begin
        if (reset) begin
            sq_live <= '0;
            for (int i = 0; i < MEM_BLOCKS; i++) begin
                shadow[i] <= {2{DATA_W'(i) * MEM_INIT_MULT}};
            end
        end else begin
            if (retire && sq_live[retire_idx]) begin
                sq_live[retire_idx] <= 1'b0;
                if (sq_addr_sh[retire_idx][WORD_SEL_BIT]) begin
                    shadow[ret_idx][BLOCK_W-1:DATA_W] <= sq_data_sh[retire_idx];
                end else begin
                    shadow[ret_idx][DATA_W-1:0] <= sq_data_sh[retire_idx];
                end
            end
            if (valid && is_store) begin
                sq_live[store_queue_idx]    <= 1'b1;
                sq_addr_sh[store_queue_idx] <= rs1 + imm;
                sq_data_sh[store_queue_idx] <= rs2;
            end
        end
    end

    // Age counts cycles since the missing load was issued
    always_ff @(posedge clock) begin
        if (reset) begin
            pend <= 1'b0;
            age  <= 0;
        end else if (new_load && !cdb_valid) begin
            pend     <= 1'b1;
            age      <= 1;
            exp_idx  <= issue_idx;
            exp_dest <= dest_tag;
        end else if (pend && cdb_valid) begin
            pend <= 1'b0;
        end else if (pend) begin
            age <= age + 1;
        end
    end

    // ========================================================================
    // Protocol and data assertions
    // ========================================================================

    a_quiet: assert property (@(posedge clock) disable iff (reset)
        !valid && !busy |-> !cdb_request && !cdb_valid)
        else flag("CDB active with no operation and no pending load");

    a_busy_source: assert property (@(posedge clock) disable iff (reset)
        !new_load && !busy |=> !busy)
        else flag("busy rose without a load being issued");

    a_no_load_busy: assert property (@(posedge clock) disable iff (reset)
        valid && is_load |-> !busy)
        else flag("load issued while busy was high");

    a_store_resp: assert property (@(posedge clock) disable iff (reset)
        valid && is_store && !busy |-> cdb_request && !cdb_valid)
        else flag("store did not signal completion without a result");

    a_hit_result: assert property (@(posedge clock) disable iff (reset)
        new_load && cdb_valid |-> cdb_request && cdb_tag == dest_tag &&
                                  cdb_data == shadow[issue_idx])
        else flag("load hit returned wrong request, tag or block");

    a_miss_busy: assert property (@(posedge clock) disable iff (reset)
        new_load && !cdb_valid |=> busy)
        else flag("busy did not rise after a load miss");

    a_miss_time: assert property (@(posedge clock) disable iff (reset)
        pend |-> cdb_valid == (age == MISS_LATENCY + 2) &&
                 cdb_request == (age == MISS_LATENCY + 2))
        else flag("missed load did not complete at the fixed latency");

    a_miss_result: assert property (@(posedge clock) disable iff (reset)
        pend && cdb_valid |-> cdb_tag == exp_dest && cdb_data == shadow[exp_idx])
        else flag("missed load returned wrong tag or block");

endmodule

bind mem_subsystem mem_subsystem_chk u_chk (.*);

// ==== tb/mem_subsystem_tb.sv ====
`timescale 1ns/1ps

module mem_subsystem_tb import mem_pkg::*; ();

    // Random run length and a cycle budget for a miss on every op
    localparam int          RAND_OPS    = 75;
    localparam int          CYCLE_LIMIT = 200 + RAND_OPS * 2 * (MISS_LATENCY + 6);
    localparam logic [15:0] LFSR_SEED   = 16'd13388;

    logic                clock;
    logic                reset;
    logic                valid;
    mem_func_t           func;
    logic [DATA_W-1:0]   rs1;
    logic [DATA_W-1:0]   rs2;
    logic [DATA_W-1:0]   imm;
    logic [SQ_IDX_W-1:0] store_queue_idx;
    logic [PTAG_W-1:0]   dest_tag;
    logic                retire;
    logic [SQ_IDX_W-1:0] retire_idx;
    logic                cdb_request;
    logic                cdb_valid;
    logic [PTAG_W-1:0]   cdb_tag;
    logic [BLOCK_W-1:0]  cdb_data;
    logic                busy;

    logic [15:0] lfsr = LFSR_SEED;
    int          tb_errors = 0;
    int          tests_done = 0;
    int          cycle_count = 0;
    int          total_fail;

    mem_subsystem DUT (.*);

    initial begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    // Hang guard
    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Checks failed");
            $finish;
        end
    end

    // ========================================================================
    // Helpers
    // ========================================================================

    // Galois LFSR with polynomial x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end else begin
            return s >> 1;
        end
    endfunction

    // One step per bit taken
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = lfsr_step(lfsr);
            v = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    task automatic report_fail(input string what);
        tb_errors++;
        $display("FAIL %0t %s", $time, what);
    endtask

    task automatic end_test(input string name);
        tests_done++;
        $display("test %s finished", name);
    endtask

    // Entered and left 1 ns after an edge
    // Cycle count runs from issue to the CDB result
    task automatic run_load(input logic [DATA_W-1:0] base, input logic [DATA_W-1:0] ofs,
                            input mem_func_t f, input logic [PTAG_W-1:0] tag,
                            output int cycles);
        valid    = 1'b1;
        func     = f;
        rs1      = base;
        imm      = ofs;
        dest_tag = tag;
        cycles   = 0;
        #1;
        while (!cdb_valid) begin
            @(posedge clock);
            #1;
            valid = 1'b0;
            cycles++;
            #1;
        end
        @(posedge clock);
        #1;
        valid = 1'b0;
    endtask

    task automatic send_store(input logic [DATA_W-1:0] addr, input logic [DATA_W-1:0] data,
                              input mem_func_t f, input logic [SQ_IDX_W-1:0] idx);
        valid           = 1'b1;
        func            = f;
        rs1             = addr;
        imm             = '0;
        rs2             = data;
        store_queue_idx = idx;
        #1;
        assert (cdb_request && !cdb_valid && !busy)
            else report_fail("store issue cycle response wrong");
        @(posedge clock);
        #1;
        valid = 1'b0;
    endtask

    // Extra idle cycle lets the memory write and invalidate land
    task automatic retire_slot(input logic [SQ_IDX_W-1:0] idx);
        retire     = 1'b1;
        retire_idx = idx;
        @(posedge clock);
        #1;
        retire = 1'b0;
        @(posedge clock);
        #1;
    endtask

    // ========================================================================
    // Test sequence
    // ========================================================================

    initial begin
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] addr;
        int          cycles;
        reset           = 1'b1;
        valid           = 1'b0;
        func            = MEM_NOP;
        rs1             = '0;
        rs2             = '0;
        imm             = '0;
        store_queue_idx = '0;
        dest_tag        = '0;
        retire          = 1'b0;
        retire_idx      = '0;
        repeat (10) @(posedge clock);
        #1;
        reset = 1'b0;

        repeat (3) begin
            #1;
            assert (!cdb_request && !cdb_valid && !busy)
                else report_fail("outputs active after reset");
            @(posedge clock);
            #1;
        end
        end_test("reset_idle");

        // Tag 1, offset 2, word 0 split over base and immediate
        run_load(32'h0000_1000, 32'h0000_0010, LOAD_DOUBLE, 6'd5, cycles);
        assert (cycles == MISS_LATENCY + 2)
            else report_fail($sformatf("first load took %0d cycles", cycles));
        end_test("load_miss");

        run_load(32'h0000_1010, 32'h0, LOAD_DOUBLE, 6'd6, cycles);
        assert (cycles == 0) else report_fail("repeated load did not hit");
        run_load(32'h0000_1014, 32'h0, LOAD_WORD, 6'd7, cycles);
        assert (cycles == 0) else report_fail("other word of cached block did not hit");
        end_test("load_hit");

        send_store(32'h0000_1014, 32'hDEAD_BEEF, STORE_WORD, 2'd1);
        assert (!busy) else report_fail("busy changed after store");
        end_test("store_issue");

        retire_slot(2'd1);
        run_load(32'h0000_1010, 32'h0, LOAD_DOUBLE, 6'd9, cycles);
        assert (cycles == MISS_LATENCY + 2)
            else report_fail("load after retire did not miss");
        end_test("retire_reload");

        // Tags 0..3, all offsets, both words
        for (int n = 0; n < RAND_OPS; n++) begin
            r = take_bits(2);
            a = take_bits(5);
            addr = {18'd0, a[4:3], 7'd0, a[2:1], a[0], 2'd0};
            if (r[1:0] == 2'd2) begin
                r = take_bits(4);
                send_store(addr, take_bits(32), mem_func_t'(4'd6 + {2'b00, r[3:2]}), r[1:0]);
            end else if (r[1:0] == 2'd3) begin
                r = take_bits(2);
                retire_slot(r[1:0]);
            end else begin
                r = take_bits(8);
                run_load(addr, 32'h0, mem_func_t'({2'b00, r[7:6]}), r[5:0], cycles);
                assert (cycles == 0 || cycles == MISS_LATENCY + 2)
                    else report_fail($sformatf("random load took %0d cycles", cycles));
            end
        end
        end_test("random_mix");

        repeat (3) @(posedge clock);
        total_fail = tb_errors + DUT.u_chk.fail_count;
        $display("Tests: %0d  testbench errors: %0d  assertion failures: %0d",
                 tests_done, tb_errors, DUT.u_chk.fail_count);
        if (total_fail == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule
